/* tqv_periph_pkg.sv */
package tqv_periph_pkg;

    // Bus and pin widths
    localparam int addr_w    = 11;
    localparam int data_w    = 32;
    localparam int num_slots = 16;
    localparam int num_pins  = 8;

    // Transfer size code from the core, idle when all ones
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10,
        size_idle = 2'b11
    } size_t;

    // Word access region, 64 bytes per slot
    typedef struct packed {
        logic       region;
        logic [3:0] slot;
        logic [5:0] offset;
    } user_addr_t;

    // Byte access region, 16 bytes per slot
    typedef struct packed {
        logic       region;
        logic [1:0] unused;
        logic [3:0] index;
        logic [3:0] offset;
    } simple_addr_t;

    // Region bit selects which view is valid
    typedef union packed {
        user_addr_t   user;
        simple_addr_t simple;
    } periph_addr_t;

    // Output pin source, top bit picks the simple region
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } func_sel_t;

    localparam logic [3:0] slot_gpio    = 4'd1;
    localparam logic [3:0] slot_scratch = 4'd2;
    localparam logic [3:0] slot_edge    = 4'd0;

    localparam logic [5:0] gpio_out_ofs = 6'h00;
    localparam logic [5:0] gpio_in_ofs  = 6'h04;
    localparam logic [5:0] gpio_sel_ofs = 6'h20;

endpackage

/* periph_bus_if.sv */
`timescale 1ns/100ps

// Decoded request shared by all peripherals
interface periph_bus_if;

    tqv_periph_pkg::periph_addr_t             addr;
    logic [tqv_periph_pkg::data_w-1:0]        wdata;
    tqv_periph_pkg::size_t                    write_size;
    tqv_periph_pkg::size_t                    read_size;
    logic [tqv_periph_pkg::num_slots-1:0]     user_sel;
    logic [tqv_periph_pkg::num_slots-1:0]     simple_sel;

    modport decoder (
        output addr,
        output wdata,
        output write_size,
        output read_size,
        output user_sel,
        output simple_sel
    );

    modport periph (
        input addr,
        input wdata,
        input write_size,
        input read_size,
        input user_sel,
        input simple_sel
    );

endinterface

/* bus_decoder.sv */
`timescale 1ns/100ps

module bus_decoder (
    input  tqv_periph_pkg::periph_addr_t      i_addr,
    input  logic [tqv_periph_pkg::data_w-1:0] i_data,
    input  tqv_periph_pkg::size_t             i_data_write_n,
    input  tqv_periph_pkg::size_t             i_data_read_n,
    input  logic                              i_busy,
    periph_bus_if.decoder                     bus
);

    assign bus.addr       = i_addr;
    assign bus.wdata      = i_data;
    assign bus.write_size = i_data_write_n;

    // Hide the read from the slots while the return register holds data,
    // so a read with side effects happens once per request
    assign bus.read_size = i_busy ? tqv_periph_pkg::size_idle : i_data_read_n;

    // One select bit per access, region bit picks the address view
    always_comb begin
        bus.user_sel   = '0;
        bus.simple_sel = '0;
        if (i_addr.simple.region) begin
            bus.simple_sel[i_addr.simple.index] = 1'b1;
        end else begin
            bus.user_sel[i_addr.user.slot] = 1'b1;
        end
    end

endmodule

/* gpio_ctrl.sv */
`timescale 1ns/100ps

module gpio_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    periph_bus_if.periph                           bus,
    input  logic [tqv_periph_pkg::num_pins-1:0]    i_ui_in,
    output logic [tqv_periph_pkg::data_w-1:0]      o_rdata,
    output logic [tqv_periph_pkg::num_pins-1:0]    o_pins,
    output tqv_periph_pkg::func_sel_t [tqv_periph_pkg::num_pins-1:0] o_func_sel
);

    localparam tqv_periph_pkg::func_sel_t scratch_pin_sel = '{
        simple: 1'b0, slot: tqv_periph_pkg::slot_scratch};
    localparam tqv_periph_pkg::func_sel_t gpio_pin_sel = '{
        simple: 1'b0, slot: tqv_periph_pkg::slot_gpio};

    logic [tqv_periph_pkg::num_pins-1:0]                       out_q;
    tqv_periph_pkg::func_sel_t [tqv_periph_pkg::num_pins-1:0]  sel_q;
    logic [5:0] ofs;
    logic       wr_en;
    logic       sel_hit;
    logic [2:0] sel_idx;

    assign ofs   = bus.addr.user.offset;
    assign wr_en = bus.user_sel[tqv_periph_pkg::slot_gpio]
                   && (bus.write_size != tqv_periph_pkg::size_idle);

    // Select registers are word aligned from the base upwards
    assign sel_hit = (ofs >= tqv_periph_pkg::gpio_sel_ofs) && (ofs[1:0] == 2'b00);
    assign sel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
            // Pins 0 and 1 start on the scratch slot
            for (int k = 0; k < tqv_periph_pkg::num_pins; k++) begin
                sel_q[k] <= (k < 2) ? scratch_pin_sel : gpio_pin_sel;
            end
        end else if (wr_en) begin
            if (ofs == tqv_periph_pkg::gpio_out_ofs) begin
                out_q <= bus.wdata[7:0];
            end
            if (sel_hit) begin
                sel_q[sel_idx] <= bus.wdata[4:0];
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (ofs == tqv_periph_pkg::gpio_out_ofs) begin
            o_rdata[7:0] = out_q;
        end else if (ofs == tqv_periph_pkg::gpio_in_ofs) begin
            o_rdata[7:0] = i_ui_in;
        end else if (sel_hit) begin
            o_rdata[4:0] = sel_q[sel_idx];
        end
    end

    assign o_pins     = out_q;
    assign o_func_sel = sel_q;

endmodule

/* scratch_periph.sv */
`timescale 1ns/100ps

module scratch_periph #(
    parameter logic [31:0] RESET_VALUE = '0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    periph_bus_if.periph                        bus,
    output logic [tqv_periph_pkg::data_w-1:0]   o_rdata,
    output logic                                o_rready,
    output logic [tqv_periph_pkg::num_pins-1:0] o_pins,
    output logic                                o_interrupt
);

    localparam logic [5:0] data_ofs = 6'h00;
    localparam logic [5:0] irq_ofs  = 6'h08;

    logic [tqv_periph_pkg::data_w-1:0] data_q;
    logic irq_q;
    logic wr_en;
    logic irq_rd;

    assign wr_en = bus.user_sel[tqv_periph_pkg::slot_scratch]
                   && (bus.write_size != tqv_periph_pkg::size_idle)
                   && (bus.addr.user.offset == data_ofs);

    // Reading the status clears it
    assign irq_rd = bus.user_sel[tqv_periph_pkg::slot_scratch]
                    && (bus.read_size != tqv_periph_pkg::size_idle)
                    && (bus.addr.user.offset == irq_ofs);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= RESET_VALUE;
            irq_q  <= 1'b0;
        end else begin
            if (wr_en) begin
                // Only the lanes covered by the size change
                case (bus.write_size)
                    tqv_periph_pkg::size_byte: data_q[7:0]  <= bus.wdata[7:0];
                    tqv_periph_pkg::size_half: data_q[15:0] <= bus.wdata[15:0];
                    default:                   data_q       <= bus.wdata;
                endcase
                irq_q <= 1'b1;
            end else if (irq_rd) begin
                irq_q <= 1'b0;
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (bus.addr.user.offset == data_ofs) begin
            o_rdata = data_q;
        end else if (bus.addr.user.offset == irq_ofs) begin
            o_rdata[0] = irq_q;
        end
    end

    assign o_rready    = 1'b1;
    assign o_pins      = data_q[7:0];
    assign o_interrupt = irq_q;

endmodule

/* edge_counter.sv */
`timescale 1ns/100ps

module edge_counter #(
    parameter int EDGE_PIN = 0,
    parameter int COUNT_W  = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    periph_bus_if.periph                        bus,
    input  logic [tqv_periph_pkg::num_pins-1:0] i_ui_in,
    output logic [7:0]                          o_rdata,
    output logic [tqv_periph_pkg::num_pins-1:0] o_pins
);

    logic [COUNT_W-1:0] count_q;
    logic pin_q;
    logic pin_prev_q;
    logic rise;
    logic wr_en;

    assign wr_en = bus.simple_sel[tqv_periph_pkg::slot_edge]
                   && (bus.write_size != tqv_periph_pkg::size_idle);

    // Registered sample, edge seen between two samples
    assign rise = pin_q && !pin_prev_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_q      <= 1'b0;
            pin_prev_q <= 1'b0;
            count_q    <= '0;
        end else begin
            pin_q      <= i_ui_in[EDGE_PIN];
            pin_prev_q <= pin_q;
            // Any write clears, wraps at the top
            if (wr_en) begin
                count_q <= '0;
            end else if (rise) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign o_rdata = (bus.addr.simple.offset == 4'h0) ? 8'(count_q) : 8'h00;
    assign o_pins  = 8'(count_q);

endmodule

/* read_return.sv */
`timescale 1ns/100ps

module read_return (
    input  logic                                clk,
    input  logic                                rst_n,
    periph_bus_if.periph                        bus,
    input  logic [tqv_periph_pkg::data_w-1:0]
                 i_user_rdata [tqv_periph_pkg::slot_gpio:tqv_periph_pkg::slot_scratch],
    input  logic i_user_rready [tqv_periph_pkg::slot_gpio:tqv_periph_pkg::slot_scratch],
    input  logic [7:0]                          i_simple_rdata,
    input  tqv_periph_pkg::size_t               i_data_read_n,
    input  tqv_periph_pkg::size_t               i_data_write_n,
    input  logic                                i_data_read_complete,
    output logic [tqv_periph_pkg::data_w-1:0]   o_data_out,
    output logic                                o_data_ready,
    output logic                                o_busy
);

    logic [tqv_periph_pkg::data_w-1:0] slot_rdata;
    logic [tqv_periph_pkg::data_w-1:0] data_q;
    logic slot_rready;
    logic read_req;
    logic capture;
    logic hold_q;
    logic ready_q;

    // Slot 0 never answers, other empty slots read as zero
    always_comb begin
        slot_rdata  = '0;
        slot_rready = 1'b1;
        if (bus.addr.simple.region) begin
            if (bus.addr.simple.index == tqv_periph_pkg::slot_edge) begin
                slot_rdata = {24'h0, i_simple_rdata};
            end
        end else begin
            case (bus.addr.user.slot)
                4'd0: slot_rready = 1'b0;
                tqv_periph_pkg::slot_gpio: begin
                    slot_rdata  = i_user_rdata[tqv_periph_pkg::slot_gpio];
                    slot_rready = i_user_rready[tqv_periph_pkg::slot_gpio];
                end
                tqv_periph_pkg::slot_scratch: begin
                    slot_rdata  = i_user_rdata[tqv_periph_pkg::slot_scratch];
                    slot_rready = i_user_rready[tqv_periph_pkg::slot_scratch];
                end
                default: slot_rready = 1'b1;
            endcase
        end
    end

    assign read_req = (i_data_read_n != tqv_periph_pkg::size_idle);
    assign capture  = read_req && slot_rready && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && slot_rready;
        end
    end

    // Value stays put until the core completes the read
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= slot_rdata;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_data_write_n != tqv_periph_pkg::size_idle);
    assign o_busy       = ready_q;

endmodule

/* pin_mux.sv */
`timescale 1ns/100ps

module pin_mux (
    input  tqv_periph_pkg::func_sel_t [tqv_periph_pkg::num_pins-1:0] i_func_sel,
    input  logic [tqv_periph_pkg::num_pins-1:0]
                 i_user_pins [tqv_periph_pkg::slot_gpio:tqv_periph_pkg::slot_scratch],
    input  logic [tqv_periph_pkg::num_pins-1:0] i_simple_pins,
    output logic [tqv_periph_pkg::num_pins-1:0] o_uo_out
);

    // Pin k takes bit k of its chosen slot's pin byte
    always_comb begin
        for (int k = 0; k < tqv_periph_pkg::num_pins; k++) begin
            o_uo_out[k] = 1'b0;
            if (i_func_sel[k].simple) begin
                if (i_func_sel[k].slot == tqv_periph_pkg::slot_edge) begin
                    o_uo_out[k] = i_simple_pins[k];
                end
            end else begin
                case (i_func_sel[k].slot)
                    tqv_periph_pkg::slot_gpio:
                        o_uo_out[k] = i_user_pins[tqv_periph_pkg::slot_gpio][k];
                    tqv_periph_pkg::slot_scratch:
                        o_uo_out[k] = i_user_pins[tqv_periph_pkg::slot_scratch][k];
                    default:
                        o_uo_out[k] = 1'b0;
                endcase
            end
        end
    end

endmodule

/* tqv_peripherals.sv */
`timescale 1ns/100ps

module tqv_peripherals #(
    parameter int EDGE_PIN = 0,
    parameter int COUNT_W  = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  i_ui_in,
    output logic [7:0]  o_uo_out,
    input  logic [10:0] i_addr,
    input  logic [31:0] i_data,
    input  logic [1:0]  i_data_write_n,
    input  logic [1:0]  i_data_read_n,
    output logic [31:0] o_data_out,
    output logic        o_data_ready,
    input  logic        i_data_read_complete,
    output logic        o_interrupt
);

    localparam logic [3:0] lo = tqv_periph_pkg::slot_gpio;
    localparam logic [3:0] hi = tqv_periph_pkg::slot_scratch;

    tqv_periph_pkg::size_t write_size;
    tqv_periph_pkg::size_t read_size;
    logic        busy;
    logic [31:0] user_rdata  [lo:hi];
    logic        user_rready [lo:hi];
    logic [7:0]  user_pins   [lo:hi];
    logic [7:0]  simple_rdata;
    logic [7:0]  simple_pins;
    tqv_periph_pkg::func_sel_t [7:0] func_sel;

    assign write_size = tqv_periph_pkg::size_t'(i_data_write_n);
    assign read_size  = tqv_periph_pkg::size_t'(i_data_read_n);

    // GPIO reads never stall
    assign user_rready[lo] = 1'b1;

    periph_bus_if i_bus ();

    bus_decoder i_bus_decoder (
        .i_addr(i_addr), .i_data(i_data), .i_data_write_n(write_size),
        .i_data_read_n(read_size), .i_busy(busy), .bus(i_bus.decoder)
    );

    gpio_ctrl i_gpio_ctrl (
        .clk(clk), .rst_n(rst_n), .bus(i_bus.periph), .i_ui_in(i_ui_in),
        .o_rdata(user_rdata[lo]), .o_pins(user_pins[lo]), .o_func_sel(func_sel)
    );

    scratch_periph #(.RESET_VALUE(32'h0)) i_scratch_periph (
        .clk(clk), .rst_n(rst_n), .bus(i_bus.periph), .o_rdata(user_rdata[hi]),
        .o_rready(user_rready[hi]), .o_pins(user_pins[hi]), .o_interrupt(o_interrupt)
    );

    edge_counter #(.EDGE_PIN(EDGE_PIN), .COUNT_W(COUNT_W)) i_edge_counter (
        .clk(clk), .rst_n(rst_n), .bus(i_bus.periph), .i_ui_in(i_ui_in),
        .o_rdata(simple_rdata), .o_pins(simple_pins)
    );

    read_return i_read_return (
        .clk(clk), .rst_n(rst_n), .bus(i_bus.periph),
        .i_user_rdata(user_rdata), .i_user_rready(user_rready),
        .i_simple_rdata(simple_rdata), .i_data_read_n(read_size),
        .i_data_write_n(write_size), .i_data_read_complete(i_data_read_complete),
        .o_data_out(o_data_out), .o_data_ready(o_data_ready), .o_busy(busy)
    );

    pin_mux i_pin_mux (
        .i_func_sel(func_sel), .i_user_pins(user_pins),
        .i_simple_pins(simple_pins), .o_uo_out(o_uo_out)
    );

endmodule

/* tb_tqv_peripherals.sv */
`timescale 1ns/100ps

module tb_tqv_peripherals;

    localparam int edge_pulses = 265;
    // Edge test needs about 2 * edge_pulses cycles and the other tests far fewer
    localparam int watchdog_cycles = 2000;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_ui_in;
    logic [7:0]  o_uo_out;
    logic [10:0] i_addr;
    logic [31:0] i_data;
    logic [1:0]  i_data_write_n;
    logic [1:0]  i_data_read_n;
    logic [31:0] o_data_out;
    logic        o_data_ready;
    logic        i_data_read_complete;
    logic        o_interrupt;

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;

    // Expected state of the peripherals
    logic [7:0]  gpio_model;
    logic [31:0] scratch_model;
    logic [7:0]  count_model;
    tqv_periph_pkg::func_sel_t sel_model [8];

    tqv_peripherals #(.EDGE_PIN(0), .COUNT_W(8)) i_tqv_peripherals (
        .clk(clk), .rst_n(rst_n), .i_ui_in(i_ui_in), .o_uo_out(o_uo_out),
        .i_addr(i_addr), .i_data(i_data), .i_data_write_n(i_data_write_n),
        .i_data_read_n(i_data_read_n), .o_data_out(o_data_out),
        .o_data_ready(o_data_ready), .i_data_read_complete(i_data_read_complete),
        .o_interrupt(o_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [10:0] user_addr(input logic [3:0] slot, input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [10:0] simple_addr(input logic [3:0] idx, input logic [3:0] ofs);
        return {1'b1, 2'b00, idx, ofs};
    endfunction

    function automatic logic [10:0] gpio_sel_addr(input int k);
        return user_addr(tqv_periph_pkg::slot_gpio, tqv_periph_pkg::gpio_sel_ofs + 6'(4 * k));
    endfunction

    // Pin k shows bit k of the pin byte of the slot its select names
    function automatic logic [7:0] expected_pins();
        logic [7:0] pins;
        pins = '0;
        for (int k = 0; k < 8; k++) begin
            if (sel_model[k].simple) begin
                if (sel_model[k].slot == tqv_periph_pkg::slot_edge) begin
                    pins[k] = count_model[k];
                end
            end else if (sel_model[k].slot == tqv_periph_pkg::slot_gpio) begin
                pins[k] = gpio_model[k];
            end else if (sel_model[k].slot == tqv_periph_pkg::slot_scratch) begin
                pins[k] = scratch_model[k];
            end
        end
        return pins;
    endfunction

    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_word(input string name, input logic [tqv_periph_pkg::data_w-1:0] got,
                              input logic [tqv_periph_pkg::data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            record_error();
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pins(input string name, input logic [tqv_periph_pkg::num_pins-1:0] got,
                              input logic [tqv_periph_pkg::num_pins-1:0] exp);
        checks++;
        if (got !== exp) begin
            record_error();
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            record_error();
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic start_test();
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
    endtask

    // Ready must answer in the same cycle as the write
    task automatic bus_write(input logic [10:0] addr, input tqv_periph_pkg::size_t size,
                             input logic [31:0] data);
        i_addr         = addr;
        i_data         = data;
        i_data_write_n = size;
        #1;
        check_bit("o_data_ready", o_data_ready, 1'b1);
        next_cycle();
        i_data_write_n = tqv_periph_pkg::size_idle;
    endtask

    task automatic bus_read(input logic [10:0] addr, input tqv_periph_pkg::size_t size,
                            output logic [31:0] data);
        int waited;
        i_addr        = addr;
        i_data_read_n = size;
        waited        = 0;
        data          = '0;
        do begin
            next_cycle();
            waited++;
        end while (!o_data_ready && waited < 16);
        if (!o_data_ready) begin
            record_error();
            $display("read of address %h got no ready within 16 cycles", addr);
        end else begin
            data = o_data_out;
            // Returned value must not move while the request stays up
            repeat (3) begin
                next_cycle();
                check_word("o_data_out", o_data_out, data);
            end
        end
        i_data_read_n        = tqv_periph_pkg::size_idle;
        i_data_read_complete = 1'b1;
        next_cycle();
        i_data_read_complete = 1'b0;
    endtask

    task automatic test_reset_state();
        logic [31:0] value;
        start_test();
        check_pins("o_uo_out", o_uo_out, 8'h00);
        check_bit("o_interrupt", o_interrupt, 1'b0);
        check_bit("o_data_ready", o_data_ready, 1'b0);
        for (int k = 0; k < 8; k++) begin
            sel_model[k] = (k < 2) ? 5'd2 : 5'd1;
            bus_read(gpio_sel_addr(k), tqv_periph_pkg::size_word, value);
            check_word("o_data_out", value, {27'h0, sel_model[k]});
        end
        finish_test("reset state");
    endtask

    task automatic test_gpio();
        logic [31:0] data;
        logic [31:0] value;
        start_test();
        for (int i = 0; i < 4; i++) begin
            data = random_bits(32);
            bus_write(user_addr(tqv_periph_pkg::slot_gpio, tqv_periph_pkg::gpio_out_ofs),
                      tqv_periph_pkg::size_word, data);
            gpio_model = data[7:0];
            check_pins("o_uo_out", o_uo_out, expected_pins());
            bus_read(user_addr(tqv_periph_pkg::slot_gpio, tqv_periph_pkg::gpio_out_ofs),
                     tqv_periph_pkg::size_word, value);
            check_word("o_data_out", value, {24'h0, gpio_model});
            i_ui_in = 8'(random_bits(8));
            bus_read(user_addr(tqv_periph_pkg::slot_gpio, tqv_periph_pkg::gpio_in_ofs),
                     tqv_periph_pkg::size_word, value);
            check_word("o_data_out", value, {24'h0, i_ui_in});
        end
        i_ui_in = '0;
        finish_test("gpio");
    endtask

    task automatic test_scratch_lanes();
        tqv_periph_pkg::size_t size;
        logic [31:0] mask;
        logic [31:0] data;
        logic [31:0] value;
        start_test();
        for (int i = 0; i < 3; i++) begin
            size = (i == 0) ? tqv_periph_pkg::size_byte
                 : (i == 1) ? tqv_periph_pkg::size_half : tqv_periph_pkg::size_word;
            mask = (i == 0) ? 32'h0000_00ff : (i == 1) ? 32'h0000_ffff : 32'hffff_ffff;
            data = random_bits(32);
            bus_write(user_addr(tqv_periph_pkg::slot_scratch, 6'h00), size, data);
            scratch_model = (scratch_model & ~mask) | (data & mask);
            bus_read(user_addr(tqv_periph_pkg::slot_scratch, 6'h00),
                     tqv_periph_pkg::size_word, value);
            check_word("o_data_out", value, scratch_model);
            check_pins("o_uo_out", o_uo_out, expected_pins());
        end
        finish_test("scratch lanes");
    endtask

    task automatic test_interrupt();
        logic [31:0] value;
        start_test();
        scratch_model = random_bits(32);
        bus_write(user_addr(tqv_periph_pkg::slot_scratch, 6'h00), tqv_periph_pkg::size_word,
                  scratch_model);
        check_bit("o_interrupt", o_interrupt, 1'b1);
        // Status read clears the flag so only the first read may see it
        bus_read(user_addr(tqv_periph_pkg::slot_scratch, 6'h08), tqv_periph_pkg::size_word, value);
        check_word("o_data_out", value, 32'h1);
        check_bit("o_interrupt", o_interrupt, 1'b0);
        bus_read(user_addr(tqv_periph_pkg::slot_scratch, 6'h08), tqv_periph_pkg::size_word, value);
        check_word("o_data_out", value, 32'h0);
        finish_test("interrupt");
    endtask

    task automatic test_edge_and_pins();
        logic [31:0] value;
        start_test();
        i_ui_in = '0;
        repeat (3) next_cycle();
        bus_write(simple_addr(tqv_periph_pkg::slot_edge, 4'h0), tqv_periph_pkg::size_byte, '0);
        for (int i = 0; i < edge_pulses; i++) begin
            i_ui_in[0] = 1'b1;
            next_cycle();
            i_ui_in[0] = 1'b0;
            next_cycle();
        end
        // Input sampling adds two register stages
        repeat (3) next_cycle();
        count_model = 8'(edge_pulses % 256);
        bus_read(simple_addr(tqv_periph_pkg::slot_edge, 4'h0), tqv_periph_pkg::size_byte, value);
        check_word("o_data_out", value, {24'h0, count_model});
        bus_write(gpio_sel_addr(3), tqv_periph_pkg::size_word, 32'h10);
        sel_model[3] = 5'h10;
        bus_write(gpio_sel_addr(0), tqv_periph_pkg::size_word, 32'h02);
        sel_model[0] = 5'h02;
        check_pins("o_uo_out", o_uo_out, expected_pins());
        bus_write(simple_addr(tqv_periph_pkg::slot_edge, 4'h0), tqv_periph_pkg::size_byte, '0);
        count_model = '0;
        bus_read(simple_addr(tqv_periph_pkg::slot_edge, 4'h0), tqv_periph_pkg::size_byte, value);
        check_word("o_data_out", value, 32'h0);
        check_pins("o_uo_out", o_uo_out, expected_pins());
        finish_test("edge counter and pins");
    endtask

    task automatic test_empty_slots();
        logic [31:0] value;
        start_test();
        bus_read(user_addr(4'd5, 6'h00), tqv_periph_pkg::size_word, value);
        check_word("o_data_out", value, 32'h0);
        bus_read(simple_addr(4'd9, 4'h0), tqv_periph_pkg::size_byte, value);
        check_word("o_data_out", value, 32'h0);
        // Slot 0 keeps ready low for as long as the read is held
        i_addr        = user_addr(4'd0, 6'h00);
        i_data_read_n = tqv_periph_pkg::size_word;
        repeat (4) begin
            next_cycle();
            check_bit("o_data_ready", o_data_ready, 1'b0);
        end
        i_data_read_n = tqv_periph_pkg::size_idle;
        next_cycle();
        bus_write(user_addr(4'd5, 6'h00), tqv_periph_pkg::size_word, random_bits(32));
        bus_write(simple_addr(4'd9, 4'h0), tqv_periph_pkg::size_byte, random_bits(32));
        bus_write(user_addr(4'd0, 6'h00), tqv_periph_pkg::size_half, random_bits(32));
        finish_test("empty slots");
    endtask

    initial begin
        lfsr_state           = 32'h64b6_49d9;
        checks               = 0;
        errors               = 0;
        test_errors          = 0;
        tests_run            = 0;
        gpio_model           = '0;
        scratch_model        = '0;
        count_model          = '0;
        rst_n                = 1'b0;
        i_ui_in              = '0;
        i_addr               = '0;
        i_data               = '0;
        i_data_write_n       = tqv_periph_pkg::size_idle;
        i_data_read_n        = tqv_periph_pkg::size_idle;
        i_data_read_complete = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        test_reset_state();
        test_gpio();
        test_scratch_lanes();
        test_interrupt();
        test_edge_and_pins();
        test_empty_slots();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
tqv_periph_pkg.sv
periph_bus_if.sv
bus_decoder.sv
gpio_ctrl.sv
scratch_periph.sv
edge_counter.sv
read_return.sv
pin_mux.sv
tqv_peripherals.sv
tb_tqv_peripherals.sv

/* Bender.yml */
package:
  name: tqv_peripherals

sources:
  - tqv_periph_pkg.sv
  - periph_bus_if.sv
  - bus_decoder.sv
  - gpio_ctrl.sv
  - scratch_periph.sv
  - edge_counter.sv
  - read_return.sv
  - pin_mux.sv
  - tqv_peripherals.sv
  - target: simulation
    files:
      - tb_tqv_peripherals.sv
